//--- src/udp_pkg.sv
package udp_pkg;

    ////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////

    // parallel lanes per vector
    localparam int LANES      = 4;
    // accumulator lane width from the conv core
    localparam int ACC_W      = 32;
    // quantized lane width
    localparam int Q_W        = 8;
    // bias vector store entries
    localparam int BIAS_DEPTH = 8;

    // int8 saturation limits
    localparam int Q_MAX      = 127;
    localparam int Q_MIN      = -128;

    ////////////////////////////////////////////////////////////////////
    // lane and vector types
    ////////////////////////////////////////////////////////////////////

    // one accumulator lane, also scale and alpha
    typedef logic signed [ACC_W-1:0] acc_t;
    // full input vector, lane 0 in the low bits
    typedef acc_t [LANES-1:0] acc_vec_t;

    // one int8 result lane
    typedef logic signed [Q_W-1:0] q_t;
    // packed int8 lanes, this is the fifo word
    typedef q_t [LANES-1:0] q_vec_t;

    // requant shift amount c
    typedef logic [4:0] shift_t;
    // replay batch count, 1..BIAS_DEPTH
    typedef logic [3:0] batch_t;
    // bias store index
    typedef logic [$clog2(BIAS_DEPTH)-1:0] bias_idx_t;

    ////////////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////////////

    // activation order
    typedef enum logic {
        ACT_QUANT_RELU  = 1'b0,
        ACT_PRELU_QUANT = 1'b1
    } act_sel_e;

    // bias store load states
    typedef enum logic [1:0] {
        BIAS_EMPTY   = 2'd0,
        BIAS_LOADING = 2'd1,
        BIAS_READY   = 2'd2
    } bias_state_e;

endpackage

//--- src/udp_bias_stage.sv
module udp_bias_stage import udp_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_adv,
    input  logic     i_bias_start,
    input  logic     i_bias_valid,
    input  acc_vec_t i_bias_data,
    input  logic     i_bias_done,
    input  logic     i_bias_en,
    input  batch_t   i_bias_batch,
    input  logic     i_valid,
    input  acc_vec_t i_data,
    output logic     o_bias_ready,
    output logic     o_valid,
    output acc_vec_t o_data
);

    bias_state_e state;
    acc_vec_t    bias_mem [BIAS_DEPTH];
    bias_idx_t   wr_idx;
    bias_idx_t   rd_idx;
    batch_t      rd_next;
    logic        load_wr;
    logic        load_end;
    logic        use_bias;
    acc_vec_t    bias_vec;
    acc_vec_t    sum;

    ////////////////////////////////////////////////////////////////////
    // load fsm
    ////////////////////////////////////////////////////////////////////

    // start wins over anything else in the same cycle
    assign load_wr  = (state == BIAS_LOADING) && i_bias_valid && !i_bias_start;
    assign load_end = (state == BIAS_LOADING) && i_bias_done && !i_bias_start;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state  <= BIAS_EMPTY;
            wr_idx <= '0;
        end else if (i_bias_start) begin
            state  <= BIAS_LOADING;
            wr_idx <= '0;
        end else begin
            if (load_wr) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (load_end) begin
                state <= BIAS_READY;
            end
        end
    end

    // entry write, a valid beside done still lands
    always_ff @(posedge i_clk) begin
        if (load_wr) begin
            bias_mem[wr_idx] <= i_bias_data;
        end
    end

    assign o_bias_ready = (state == BIAS_READY);

    ////////////////////////////////////////////////////////////////////
    // batch replay
    ////////////////////////////////////////////////////////////////////

    // index only moves on a vector that takes a bias
    assign use_bias = i_adv && i_valid && i_bias_en;
    assign rd_next  = batch_t'(rd_idx) + 1'b1;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            rd_idx <= '0;
        end else if (i_bias_start || load_end) begin
            rd_idx <= '0;
        end else if (use_bias) begin
            // wrap after batch entries
            if (rd_next >= i_bias_batch) begin
                rd_idx <= '0;
            end else begin
                rd_idx <= bias_idx_t'(rd_next);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // lane add
    ////////////////////////////////////////////////////////////////////

    assign bias_vec = i_bias_en ? bias_mem[rd_idx] : '0;

    // 32 bit wraparound per lane
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            sum[l] = i_data[l] + bias_vec[l];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_valid <= 1'b0;
        end else if (i_adv) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            o_data <= sum;
        end
    end

endmodule

//--- src/udp_quant_lane.sv
module udp_quant_lane import udp_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_adv,
    input  logic   i_valid,
    input  acc_t   i_x,
    input  acc_t   i_scale,
    input  shift_t i_shift,
    output logic   o_valid,
    output q_t     o_q
);

    // full width product, no overflow before the shift
    logic signed [2*ACC_W-1:0] prod;
    logic signed [2*ACC_W-1:0] scaled_d;
    logic signed [2*ACC_W-1:0] scaled_q;
    logic                      valid_q;

    assign prod     = i_x * i_scale;
    // arithmetic shift keeps the sign
    assign scaled_d = prod >>> i_shift;

    // stage 1, scale and shift
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            valid_q <= 1'b0;
        end else if (i_adv) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            scaled_q <= scaled_d;
        end
    end

    // stage 2, clamp to int8
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_valid <= 1'b0;
        end else if (i_adv) begin
            o_valid <= valid_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            if (scaled_q > Q_MAX) begin
                o_q <= q_t'(Q_MAX);
            end else if (scaled_q < Q_MIN) begin
                o_q <= q_t'(Q_MIN);
            end else begin
                o_q <= q_t'(scaled_q);
            end
        end
    end

endmodule

//--- src/udp_relu_path.sv
module udp_relu_path import udp_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_adv,
    input  logic     i_valid,
    input  acc_vec_t i_data,
    input  acc_t     i_scale,
    input  shift_t   i_shift,
    output logic     o_valid,
    output q_vec_t   o_data
);

    logic [LANES-1:0] lane_valid;
    q_vec_t           q_vec;
    logic             q_valid;

    ////////////////////////////////////////////////////////////////////
    // requant, 2 cycles
    ////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < LANES; l++) begin : g_quant
        udp_quant_lane u_quant (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_adv   (i_adv),
            .i_valid (i_valid),
            .i_x     (i_data[l]),
            .i_scale (i_scale),
            .i_shift (i_shift),
            .o_valid (lane_valid[l]),
            .o_q     (q_vec[l])
        );
    end

    // all lanes run in lockstep
    assign q_valid = &lane_valid;

    ////////////////////////////////////////////////////////////////////
    // relu, 1 cycle
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            o_valid <= 1'b0;
        end else if (i_adv) begin
            o_valid <= q_valid;
        end
    end

    // negative lanes go to zero, valid is kept
    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            for (int l = 0; l < LANES; l++) begin
                o_data[l] <= q_vec[l][Q_W-1] ? '0 : q_vec[l];
            end
        end
    end

endmodule

//--- src/udp_prelu_path.sv
module udp_prelu_path import udp_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_adv,
    input  logic     i_valid,
    input  acc_vec_t i_data,
    input  acc_t     i_alpha,
    input  acc_t     i_scale,
    input  shift_t   i_shift,
    output logic     o_valid,
    output q_vec_t   o_data
);

    acc_vec_t         prelu_d;
    acc_vec_t         prelu_q;
    logic             prelu_valid;
    logic [LANES-1:0] lane_valid;

    ////////////////////////////////////////////////////////////////////
    // prelu, 1 cycle
    ////////////////////////////////////////////////////////////////////

    // negative lanes scaled by alpha, low 32 bits only
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (i_data[l][ACC_W-1]) begin
                prelu_d[l] = acc_t'(i_data[l] * i_alpha);
            end else begin
                prelu_d[l] = i_data[l];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            prelu_valid <= 1'b0;
        end else if (i_adv) begin
            prelu_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            prelu_q <= prelu_d;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // requant, 2 cycles
    ////////////////////////////////////////////////////////////////////

    for (genvar l = 0; l < LANES; l++) begin : g_quant
        udp_quant_lane u_quant (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_adv   (i_adv),
            .i_valid (prelu_valid),
            .i_x     (prelu_q[l]),
            .i_scale (i_scale),
            .i_shift (i_shift),
            .o_valid (lane_valid[l]),
            .o_q     (o_data[l])
        );
    end

    // lanes share one valid, any would do
    assign o_valid = &lane_valid;

endmodule

//--- src/udp_out_select.sv
module udp_out_select import udp_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_adv,
    input  act_sel_e i_act_sel,
    input  logic     i_relu_valid,
    input  q_vec_t   i_relu_data,
    input  logic     i_prelu_valid,
    input  q_vec_t   i_prelu_data,
    output q_vec_t   o_data,
    output logic     o_fifo_push
);

    logic push_q;

    // word and valid from the active path
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            push_q <= 1'b0;
        end else if (i_adv) begin
            push_q <= (i_act_sel == ACT_PRELU_QUANT) ? i_prelu_valid : i_relu_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_adv) begin
            o_data <= (i_act_sel == ACT_PRELU_QUANT) ? i_prelu_data : i_relu_data;
        end
    end

    // held word goes out on the next edge with room in the fifo
    assign o_fifo_push = push_q && i_adv;

endmodule

//--- src/udp_top.sv
module udp_top import udp_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    // conv core stream
    input  logic     i_valid,
    input  acc_vec_t i_data,
    output logic     o_ready,
    // bias load
    input  logic     i_bias_start,
    input  logic     i_bias_valid,
    input  acc_vec_t i_bias_data,
    input  logic     i_bias_done,
    // static config
    input  logic     i_bias_en,
    input  batch_t   i_bias_batch,
    input  acc_t     i_scale,
    input  shift_t   i_shift,
    input  acc_t     i_alpha,
    input  act_sel_e i_act_sel,
    // output fifo
    output q_vec_t   o_data,
    output logic     o_fifo_push,
    input  logic     i_fifo_full
);

    logic     adv;
    logic     in_fire;
    logic     bias_ready;
    logic     biased_valid;
    acc_vec_t biased_data;
    logic     relu_valid;
    q_vec_t   relu_data;
    logic     prelu_valid;
    q_vec_t   prelu_data;

    ////////////////////////////////////////////////////////////////////
    // flow control
    ////////////////////////////////////////////////////////////////////

    // whole pipe moves together, stalls only on fifo full
    assign adv     = !i_fifo_full;
    // with bias on, wait for a loaded store
    assign o_ready = adv && (!i_bias_en || bias_ready);
    assign in_fire = i_valid && o_ready;

    ////////////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////////////

    udp_bias_stage u_bias (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_adv        (adv),
        .i_bias_start (i_bias_start),
        .i_bias_valid (i_bias_valid),
        .i_bias_data  (i_bias_data),
        .i_bias_done  (i_bias_done),
        .i_bias_en    (i_bias_en),
        .i_bias_batch (i_bias_batch),
        .i_valid      (in_fire),
        .i_data       (i_data),
        .o_bias_ready (bias_ready),
        .o_valid      (biased_valid),
        .o_data       (biased_data)
    );

    // both activation orders run on every vector
    udp_relu_path u_relu (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_adv   (adv),
        .i_valid (biased_valid),
        .i_data  (biased_data),
        .i_scale (i_scale),
        .i_shift (i_shift),
        .o_valid (relu_valid),
        .o_data  (relu_data)
    );

    udp_prelu_path u_prelu (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_adv   (adv),
        .i_valid (biased_valid),
        .i_data  (biased_data),
        .i_alpha (i_alpha),
        .i_scale (i_scale),
        .i_shift (i_shift),
        .o_valid (prelu_valid),
        .o_data  (prelu_data)
    );

    udp_out_select u_out (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_adv         (adv),
        .i_act_sel     (i_act_sel),
        .i_relu_valid  (relu_valid),
        .i_relu_data   (relu_data),
        .i_prelu_valid (prelu_valid),
        .i_prelu_data  (prelu_data),
        .o_data        (o_data),
        .o_fifo_push   (o_fifo_push)
    );

endmodule

//--- tb/udp_tb.sv
module udp_tb import udp_pkg::*; ();

    // run limit well above five short streams and their drains
    localparam int TIMEOUT_CYCLES = 2000;

    logic        i_clk;
    logic        i_rst;
    logic        i_valid;
    acc_vec_t    i_data;
    logic        o_ready;
    logic        i_bias_start;
    logic        i_bias_valid;
    acc_vec_t    i_bias_data;
    logic        i_bias_done;
    logic        i_bias_en;
    batch_t      i_bias_batch;
    acc_t        i_scale;
    shift_t      i_shift;
    acc_t        i_alpha;
    act_sel_e    i_act_sel;
    q_vec_t      o_data;
    logic        o_fifo_push;
    logic        i_fifo_full;

    // reference model state
    q_vec_t      exp_q[$];
    acc_vec_t    bias_ref [BIAS_DEPTH];
    int          bias_idx;
    acc_vec_t    bias_pick;
    q_vec_t      want;
    int          errors;
    int          pushes;
    int          cycles;

    udp_top uut (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .o_ready      (o_ready),
        .i_bias_start (i_bias_start),
        .i_bias_valid (i_bias_valid),
        .i_bias_data  (i_bias_data),
        .i_bias_done  (i_bias_done),
        .i_bias_en    (i_bias_en),
        .i_bias_batch (i_bias_batch),
        .i_scale      (i_scale),
        .i_shift      (i_shift),
        .i_alpha      (i_alpha),
        .i_act_sel    (i_act_sel),
        .o_data       (o_data),
        .o_fifo_push  (o_fifo_push),
        .i_fifo_full  (i_fifo_full)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////

    function automatic q_t sat_int8(input longint v);
        if (v > Q_MAX) begin
            return q_t'(Q_MAX);
        end
        if (v < Q_MIN) begin
            return q_t'(Q_MIN);
        end
        return q_t'(v);
    endfunction

    // bias add, activation order and requant per lane
    function automatic q_vec_t expect_word(input acc_vec_t x, input acc_vec_t b);
        q_vec_t w;
        acc_t   v;
        longint p;
        q_t     q;
        for (int l = 0; l < LANES; l++) begin
            v = x[l] + b[l];
            // prelu slope applied before requant and kept to 32 bits
            if (i_act_sel == ACT_PRELU_QUANT && v < 0) begin
                v = acc_t'(longint'(v) * longint'(i_alpha));
            end
            p = (longint'(v) * longint'(i_scale)) >>> i_shift;
            q = sat_int8(p);
            // relu on the int8 value
            if (i_act_sel == ACT_QUANT_RELU && q < 0) begin
                q = '0;
            end
            w[l] = q;
        end
        return w;
    endfunction

    // mostly moderate values with now and then a full 32 bit lane
    function automatic acc_t rand_lane();
        if ($urandom % 8 == 0) begin
            return acc_t'($urandom);
        end
        return acc_t'(int'($urandom % 4096) - 2048);
    endfunction

    function automatic acc_vec_t rand_vec();
        acc_vec_t v;
        for (int l = 0; l < LANES; l++) begin
            v[l] = rand_lane();
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // monitor sampled mid cycle where everything is settled
    ////////////////////////////////////////////////////////////////////

    always @(negedge i_clk) begin
        if (i_rst) begin
            // accepted on the coming edge
            if (i_valid && o_ready) begin
                bias_pick = i_bias_en ? bias_ref[bias_idx] : '0;
                exp_q.push_back(expect_word(i_data, bias_pick));
                if (i_bias_en) begin
                    bias_idx = (bias_idx + 1 >= i_bias_batch) ? 0 : bias_idx + 1;
                end
            end
            if (o_fifo_push) begin
                pushes++;
                assert (exp_q.size() > 0) else begin
                    $display("fifo push at %0t with no vector outstanding", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (o_data == want) else begin
                        $display("MISMATCH time=%0t signal=o_data expected=%h actual=%h",
                                 $time, want, o_data);
                        errors++;
                    end
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d words still expected",
                     cycles, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // helpers that start and end on a rising edge
    ////////////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // hold the vector until o_ready was high before an edge
    task automatic send_vec(input acc_vec_t v);
        logic took;
        i_valid <= 1'b1;
        i_data  <= v;
        took = 1'b0;
        while (!took) begin
            @(negedge i_clk);
            took = o_ready;
            @(posedge i_clk);
        end
    endtask

    task automatic send_random(input int n);
        for (int k = 0; k < n; k++) begin
            send_vec(rand_vec());
        end
    endtask

    task automatic drain_pipe();
        i_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
    endtask

    task automatic check_count(input int n, input int p0);
        assert (pushes - p0 == n) else begin
            $display("expected %0d fifo pushes but saw %0d", n, pushes - p0);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int n, input int e0);
        $display("%-16s done, %0d vectors, %0d errors", name, n, errors - e0);
    endtask

    // start pulse and n entries then done while o_ready stays low
    task automatic load_bias(input int n);
        i_bias_start <= 1'b1;
        @(posedge i_clk);
        i_bias_start <= 1'b0;
        for (int k = 0; k < n; k++) begin
            bias_ref[k] = rand_vec();
            i_bias_valid <= 1'b1;
            i_bias_data  <= bias_ref[k];
            @(posedge i_clk);
        end
        i_bias_valid <= 1'b0;
        @(negedge i_clk);
        check_bit("o_ready", o_ready, 1'b0);
        @(posedge i_clk);
        i_bias_done <= 1'b1;
        bias_idx = 0;
        @(posedge i_clk);
        i_bias_done <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        repeat (6) begin
            @(negedge i_clk);
            check_bit("o_fifo_push", o_fifo_push, 1'b0);
            check_bit("o_ready", o_ready, 1'b1);
            @(posedge i_clk);
        end
        report_test("reset idle", 0, e0);
    endtask

    task automatic quant_relu_stream();
        int e0;
        int p0;
        e0 = errors;
        p0 = pushes;
        i_act_sel <= ACT_QUANT_RELU;
        i_scale   <= 5;
        i_shift   <= 6;
        @(posedge i_clk);
        send_random(20);
        drain_pipe();
        check_count(20, p0);
        report_test("quant relu", 20, e0);
    endtask

    task automatic prelu_quant_stream();
        int e0;
        int p0;
        e0 = errors;
        p0 = pushes;
        i_act_sel <= ACT_PRELU_QUANT;
        i_alpha   <= 2;
        i_scale   <= 3;
        i_shift   <= 7;
        @(posedge i_clk);
        send_random(20);
        drain_pipe();
        check_count(20, p0);
        report_test("prelu quant", 20, e0);
    endtask

    // entries replay as 0,1,2,0,1,2,0
    task automatic bias_batch_replay();
        int e0;
        int p0;
        e0 = errors;
        p0 = pushes;
        i_bias_en    <= 1'b1;
        i_bias_batch <= 3;
        i_scale      <= 1;
        i_shift      <= 5;
        @(posedge i_clk);
        @(negedge i_clk);
        check_bit("o_ready", o_ready, 1'b0);
        @(posedge i_clk);
        load_bias(3);
        send_random(7);
        drain_pipe();
        check_count(7, p0);
        i_bias_en <= 1'b0;
        @(posedge i_clk);
        report_test("bias replay", 7, e0);
    endtask

    task automatic fifo_full_stall();
        int e0;
        int p0;
        e0 = errors;
        p0 = pushes;
        i_act_sel <= ACT_QUANT_RELU;
        @(posedge i_clk);
        fork
            send_random(16);
            begin
                // stall once the pipe is full of words
                repeat (6) @(posedge i_clk);
                i_fifo_full <= 1'b1;
                repeat (7) begin
                    @(negedge i_clk);
                    check_bit("o_fifo_push", o_fifo_push, 1'b0);
                    check_bit("o_ready", o_ready, 1'b0);
                    @(posedge i_clk);
                end
                i_fifo_full <= 1'b0;
            end
        join
        drain_pipe();
        check_count(16, p0);
        report_test("fifo full", 16, e0);
    endtask

    initial begin
        void'($urandom(4));
        errors       = 0;
        pushes       = 0;
        cycles       = 0;
        bias_idx     = 0;
        i_rst        = 1'b0;
        i_valid      = 1'b0;
        i_data       = '0;
        i_bias_start = 1'b0;
        i_bias_valid = 1'b0;
        i_bias_data  = '0;
        i_bias_done  = 1'b0;
        i_bias_en    = 1'b0;
        i_bias_batch = 4'd1;
        i_scale      = 1;
        i_shift      = '0;
        i_alpha      = 1;
        i_act_sel    = ACT_QUANT_RELU;
        i_fifo_full  = 1'b0;
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b1;
        @(posedge i_clk);
        idle_after_reset();
        quant_relu_stream();
        prelu_quant_stream();
        bias_batch_replay();
        fifo_full_stall();
        $display("pushes checked %0d, errors %0d", pushes, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- udp.f
src/udp_pkg.sv
src/udp_bias_stage.sv
src/udp_quant_lane.sv
src/udp_relu_path.sv
src/udp_prelu_path.sv
src/udp_out_select.sv
src/udp_top.sv
tb/udp_tb.sv

//--- Bender.yml
package:
  name: udp

sources:
  # package first, then leaf modules, then the top level
  - src/udp_pkg.sv
  - src/udp_bias_stage.sv
  - src/udp_quant_lane.sv
  - src/udp_relu_path.sv
  - src/udp_prelu_path.sv
  - src/udp_out_select.sv
  - src/udp_top.sv

  - target: test
    files:
      - tb/udp_tb.sv
